// File: src/uart_pkg.sv
// uart subsystem shared definitions
// frame constants, vector types, state encodings and beat structs
package uart_pkg;

	// frame shape, 1 start + 8 data + 2 stop
	localparam int clks_per_bit = 16;	// short bit period for fast sims
	localparam int data_bits    = 8;
	localparam int stop_bits    = 2;
	localparam int fifo_depth   = 8;	// also the host's starting credits

	typedef logic [7:0] uart_byte_t;
	typedef logic [4:0] clk_cnt_t;	// one bit period, with headroom
	typedef logic [3:0] bit_cnt_t;
	typedef logic [3:0] credit_cnt_t;	// 0 .. fifo_depth
	typedef logic [2:0] fifo_ptr_t;

	typedef enum logic [1:0] {
		tx_idle,
		tx_start,
		tx_data,
		tx_stop
	} tx_state_t;

	typedef enum logic [1:0] {
		rx_idle,
		rx_start,
		rx_data,
		rx_stop
	} rx_state_t;

	// host to buffer, one byte per valid cycle
	typedef struct packed {
		logic       valid;
		uart_byte_t data;
	} tx_beat_t;

	typedef struct packed {
		logic       valid;
		uart_byte_t data;
		logic       frame_err;	// first stop bit read low
	} rx_beat_t;

endpackage

// File: src/tx_credit_fifo.sv
// transmit credit buffer
// circular byte store filled by host beats and drained by the transmitter
// returns one credit to the host per byte popped
`timescale 1ns/10ps

module tx_credit_fifo (
	input  logic                 sys_clk,
	input  logic                 sys_rst_n,
	input  uart_pkg::tx_beat_t   host_beat,
	input  logic                 pop,
	output uart_pkg::uart_byte_t head,
	output logic                 not_empty,
	output logic                 credit_ret
);

	import uart_pkg::*;

	uart_byte_t  mem [fifo_depth];
	fifo_ptr_t   wr_ptr;
	fifo_ptr_t   rd_ptr;
	credit_cnt_t count;	// occupancy
	logic        full;
	logic        do_write;
	logic        do_pop;

	assign full      = (count == credit_cnt_t'(fifo_depth));
	assign not_empty = (count != '0);
	assign do_write  = host_beat.valid;
	assign do_pop    = pop && not_empty;

	// byte storage
	always_ff @(posedge sys_clk) begin
		if (do_write)
			mem[wr_ptr] <= host_beat.data;
	end

	// pointers wrap by width since depth is a power of two
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (do_write)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			count <= '0;
		end else begin
			case ({do_write, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;	// both or neither
			endcase
		end
	end

	assign head = mem[rd_ptr];

	// credit goes back in the pop cycle itself
	assign credit_ret = do_pop;

	// host only writes while it holds a credit so the buffer never overfills
	a_no_write_when_full: assert property (
		@(posedge sys_clk) disable iff (!sys_rst_n)
		host_beat.valid |-> !full
	) else $error("tx_credit_fifo: host wrote while buffer full");

	// transmitter must not pull from an empty buffer
	a_no_pop_when_empty: assert property (
		@(posedge sys_clk) disable iff (!sys_rst_n)
		pop |-> not_empty
	) else $error("tx_credit_fifo: pop while buffer empty");

endmodule

// File: src/uart_tx.sv
// uart frame serializer
// pops one byte from the credit buffer and sends start, 8 data bits lsb first
// and two stop bits, each bit held for clks_per_bit clocks
`timescale 1ns/10ps

module uart_tx (
	input  logic                 sys_clk,
	input  logic                 sys_rst_n,
	input  uart_pkg::uart_byte_t head,
	input  logic                 not_empty,
	output logic                 pop,
	output logic                 tx,
	output logic                 tx_busy
);

	import uart_pkg::*;

	tx_state_t  state;
	clk_cnt_t   clk_cnt;	// position inside current bit
	bit_cnt_t   bit_cnt;	// data or stop bit index
	uart_byte_t shift_buf;
	logic       bit_end;
	logic       data_last;
	logic       stop_last;

	assign bit_end   = (clk_cnt == clk_cnt_t'(clks_per_bit - 1));
	assign data_last = (bit_cnt == bit_cnt_t'(data_bits - 1));
	assign stop_last = (bit_cnt == bit_cnt_t'(stop_bits - 1));

	// take the next byte as soon as the line is free
	assign pop     = (state == tx_idle) && not_empty;
	assign tx_busy = (state != tx_idle);

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state <= tx_idle;
		end else begin
			case (state)
				tx_idle:
					if (pop)
						state <= tx_start;
				tx_start:
					if (bit_end)
						state <= tx_data;
				tx_data:
					if (bit_end && data_last)
						state <= tx_stop;
				tx_stop:
					if (bit_end && stop_last)
						state <= tx_idle;	// next pop can follow right away
				default:
					state <= tx_idle;
			endcase
		end
	end

	// bit period counter, held at zero while idle
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n)
			clk_cnt <= '0;
		else if (state == tx_idle || bit_end)
			clk_cnt <= '0;
		else
			clk_cnt <= clk_cnt + 1'b1;
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			bit_cnt <= '0;
		end else begin
			case (state)
				tx_data:
					if (bit_end)
						bit_cnt <= data_last ? '0 : bit_cnt + 1'b1;
				tx_stop:
					if (bit_end)
						bit_cnt <= stop_last ? '0 : bit_cnt + 1'b1;
				default:
					bit_cnt <= '0;
			endcase
		end
	end

	// byte latched at pop, shifted right as each bit goes out
	always_ff @(posedge sys_clk) begin
		if (pop)
			shift_buf <= head;
		else if (bit_end && (state == tx_start || state == tx_data))
			shift_buf <= shift_buf >> 1;
	end

	// line register, idles high
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			tx <= 1'b1;
		end else begin
			case (state)
				tx_idle:
					tx <= !pop;	// start bit follows pop
				tx_start:
					if (bit_end)
						tx <= shift_buf[0];	// lsb first
				tx_data:
					if (bit_end)
						tx <= data_last ? 1'b1 : shift_buf[0];
				default:
					tx <= 1'b1;	// stop bits
			endcase
		end
	end

	// line can only be low for a start or data bit
	a_tx_low_in_frame: assert property (
		@(posedge sys_clk) disable iff (!sys_rst_n)
		!tx |-> (state == tx_start || state == tx_data)
	) else $error("uart_tx: line low outside start or data bits");

endmodule

// File: src/uart_rx.sv
// uart frame receiver
// synchronizes the line, finds the start bit and samples every bit at its
// middle, then reports the byte with a framing-error flag
`timescale 1ns/10ps

module uart_rx (
	input  logic               sys_clk,
	input  logic               sys_rst_n,
	input  logic               rx,
	output uart_pkg::rx_beat_t rx_beat
);

	import uart_pkg::*;

	rx_state_t  state;
	logic       rx_meta;
	logic       rx_sync;
	logic       rx_d;	// previous synchronized level
	clk_cnt_t   clk_cnt;
	bit_cnt_t   bit_cnt;
	uart_byte_t shift_reg;
	logic       fall;
	logic       half_pt;
	logic       bit_end;
	logic       stop_done;
	logic       data_last;

	// two flop synchronizer plus edge history
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
			rx_d    <= 1'b1;
		end else begin
			rx_meta <= rx;
			rx_sync <= rx_meta;
			rx_d    <= rx_sync;
		end
	end

	assign fall      = rx_d && !rx_sync;
	assign half_pt   = (clk_cnt == clk_cnt_t'(clks_per_bit / 2 - 1));
	assign bit_end   = (clk_cnt == clk_cnt_t'(clks_per_bit - 1));
	assign data_last = (bit_cnt == bit_cnt_t'(data_bits - 1));
	// rest of the stop bit after its sample point
	assign stop_done = (clk_cnt == clk_cnt_t'(clks_per_bit + clks_per_bit / 2 - 1));

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state <= rx_idle;
		end else begin
			case (state)
				rx_idle:
					if (fall)
						state <= rx_start;
				rx_start:
					if (half_pt)
						state <= rx_sync ? rx_idle : rx_data;	// high again means glitch
				rx_data:
					if (bit_end && data_last)
						state <= rx_stop;
				rx_stop:
					if (stop_done)
						state <= rx_idle;	// second stop bit counts as idle
				default:
					state <= rx_idle;
			endcase
		end
	end

	// counter restarts at the start midpoint so later samples land mid-bit
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			clk_cnt <= '0;
		end else begin
			case (state)
				rx_start: clk_cnt <= half_pt ? '0 : clk_cnt + 1'b1;
				rx_data:  clk_cnt <= bit_end ? '0 : clk_cnt + 1'b1;
				rx_stop:  clk_cnt <= stop_done ? '0 : clk_cnt + 1'b1;
				default:  clk_cnt <= '0;
			endcase
		end
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n)
			bit_cnt <= '0;
		else if (state != rx_data)
			bit_cnt <= '0;
		else if (bit_end)
			bit_cnt <= data_last ? '0 : bit_cnt + 1'b1;
	end

	// lsb arrives first, so shift in from the top
	always_ff @(posedge sys_clk) begin
		if (state == rx_data && bit_end)
			shift_reg <= {rx_sync, shift_reg[7:1]};
	end

	// beat at the first stop bit sample point
	always_comb begin
		rx_beat.valid     = (state == rx_stop) && bit_end;
		rx_beat.data      = shift_reg;
		rx_beat.frame_err = !rx_sync;
	end

	a_valid_single_cycle: assert property (
		@(posedge sys_clk) disable iff (!sys_rst_n)
		rx_beat.valid |=> !rx_beat.valid
	) else $error("uart_rx: rx_beat.valid held for two cycles");

endmodule

// File: src/uart_top.sv
// uart subsystem top
// host beats go through the credit buffer into the transmitter,
// the receiver runs off its own line input
`timescale 1ns/10ps

module uart_top (
	input  logic               sys_clk,
	input  logic               sys_rst_n,
	input  uart_pkg::tx_beat_t host_beat,
	output logic               credit_ret,
	output logic               tx,
	output logic               tx_busy,
	input  logic               rx,
	output uart_pkg::rx_beat_t rx_beat
);

	import uart_pkg::*;

	uart_byte_t head;	// buffer head byte
	logic       not_empty;
	logic       pop;

	tx_credit_fifo fifo_i (
		.sys_clk    (sys_clk),
		.sys_rst_n  (sys_rst_n),
		.host_beat  (host_beat),
		.pop        (pop),
		.head       (head),
		.not_empty  (not_empty),
		.credit_ret (credit_ret)
	);

	// serializer drains the buffer one frame at a time
	uart_tx tx_i (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.head      (head),
		.not_empty (not_empty),
		.pop       (pop),
		.tx        (tx),
		.tx_busy   (tx_busy)
	);

	uart_rx rx_i (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.rx        (rx),
		.rx_beat   (rx_beat)
	);

endmodule

// File: verification/uart_tb.sv
// uart subsystem testbench
// random host traffic under credit flow control, loopback scoreboard,
// tx frame shape checks and bit-banged frames with a framing error
`timescale 1ns/10ps

module uart_tb;

	import uart_pkg::*;

	localparam int loop_bytes  = 40;
	localparam int burst_bytes = 12;
	localparam int drain_limit = 20000;	// cycles
	localparam int idle_limit  = 400;
	localparam int idle_cycles = 40;

	logic       sys_clk;
	logic       sys_rst_n;
	tx_beat_t   host_beat;
	logic       credit_ret;
	logic       tx;
	logic       tx_busy;
	logic       rx;
	rx_beat_t   rx_beat;

	logic       line_sel;	// high loops tx back into rx
	logic       bang_line;
	integer     seed;
	logic       use_gaps;
	int         credits;
	int         min_credits;
	int         gap_left;
	int         bytes_sent;
	int         credit_pulses;
	int         frames_checked;
	int         error_cnt;
	int         timeout_cnt;
	string      test_name;
	uart_byte_t send_q [$];	// bytes waiting for a credit
	uart_byte_t frame_q [$];	// bytes expected on the tx line
	logic [8:0] exp_q [$];	// {frame_err, data} expected at rx_beat

	initial begin
		sys_clk = 1'b0;
		forever #4 sys_clk = ~sys_clk;
	end

	assign rx = line_sel ? tx : bang_line;

	uart_top dut_i (
		.sys_clk    (sys_clk),
		.sys_rst_n  (sys_rst_n),
		.host_beat  (host_beat),
		.credit_ret (credit_ret),
		.tx         (tx),
		.tx_busy    (tx_busy),
		.rx         (rx),
		.rx_beat    (rx_beat)
	);

	task automatic value_mismatch(input string what, input int expected, input int actual);
		error_cnt++;
		$display("** Error [%s] %s: expected 0x%0h, actual 0x%0h",
			test_name, what, expected, actual);
	endtask

	task automatic protocol_fault(input string msg);
		error_cnt++;
		$display("Error in test %s: %s", test_name, msg);
	endtask

	// host model, spends a credit per beat and takes one back per credit_ret
	always @(posedge sys_clk) begin : host_model
		uart_byte_t next_byte;
		if (sys_rst_n) begin
			if (credit_ret) begin
				credits++;
				credit_pulses++;
			end
			if (send_q.size() > 0 && gap_left == 0 && credits > 0) begin
				next_byte = send_q.pop_front();
				host_beat.valid <= 1'b1;
				host_beat.data  <= next_byte;
				frame_q.push_back(next_byte);
				exp_q.push_back({1'b0, next_byte});
				credits--;
				bytes_sent++;
				gap_left = use_gaps ? ($random(seed) & 15) : 0;
			end else begin
				host_beat.valid <= 1'b0;
				if (gap_left > 0)
					gap_left--;
			end
			if (credits < min_credits)
				min_credits = credits;
			if (credits < 0 || credits > fifo_depth)
				protocol_fault($sformatf("host credit count left its range (%0d)", credits));
		end
	end

	// every received byte against the oldest one sent
	always @(posedge sys_clk) begin : rx_scoreboard
		logic [8:0] want;
		if (sys_rst_n && rx_beat.valid) begin
			if (exp_q.size() == 0) begin
				protocol_fault("receiver reported a byte that was never sent");
			end else begin
				want = exp_q.pop_front();
				if (rx_beat.data !== want[7:0])
					value_mismatch("rx data", int'(want[7:0]), int'(rx_beat.data));
				if (rx_beat.frame_err !== want[8])
					value_mismatch("rx frame_err", int'(want[8]), int'(rx_beat.frame_err));
			end
		end
	end

	task automatic level_cycles(input logic level, input int cycles, output int hits);
		hits = 0;
		repeat (cycles) begin
			@(posedge sys_clk);
			if (tx === level)
				hits++;
		end
	endtask

	// called on the first start-bit cycle, walks the rest of the frame
	task automatic frame_shape();
		uart_byte_t want;
		int         hits;
		if (frame_q.size() == 0) begin
			protocol_fault("tx line started a frame with no byte outstanding");
			want = '0;
		end else begin
			want = frame_q.pop_front();
		end
		level_cycles(1'b0, clks_per_bit - 1, hits);
		if (hits != clks_per_bit - 1)
			value_mismatch("start bit low cycles", clks_per_bit, hits + 1);
		for (int i = 0; i < data_bits; i++) begin
			level_cycles(want[i], clks_per_bit, hits);
			if (hits != clks_per_bit)
				value_mismatch($sformatf("data bit %0d cycles at level %b", i, want[i]),
					clks_per_bit, hits);
		end
		level_cycles(1'b1, stop_bits * clks_per_bit, hits);
		if (hits != stop_bits * clks_per_bit)
			value_mismatch("stop bits high cycles", stop_bits * clks_per_bit, hits);
		frames_checked++;
	endtask

	initial begin : tx_frame_watch
		forever begin
			@(posedge sys_clk);
			if (sys_rst_n && tx === 1'b0)
				frame_shape();
		end
	end

	task automatic wait_drained(input string what, input int limit);
		int waited;
		waited = 0;
		while ((send_q.size() != 0 || exp_q.size() != 0 || tx_busy) && waited < limit) begin
			@(negedge sys_clk);
			waited++;
		end
		if (send_q.size() != 0 || exp_q.size() != 0 || tx_busy) begin
			timeout_cnt++;
			$display("Timeout in %s: traffic still pending after %0d cycles", what, limit);
		end
		repeat (4) @(negedge sys_clk);	// let the frame watch finish
	endtask

	task automatic credit_totals();
		if (credits != fifo_depth)
			value_mismatch("host credits after drain", fifo_depth, credits);
		if (credit_pulses != bytes_sent)
			value_mismatch("credit_ret pulses vs bytes sent", bytes_sent, credit_pulses);
		if (frames_checked != bytes_sent)
			value_mismatch("frames seen on tx", bytes_sent, frames_checked);
	endtask

	task automatic hold_line(input logic level);
		repeat (clks_per_bit) begin
			@(posedge sys_clk);
			bang_line <= level;
		end
	endtask

	// start, data lsb first, first stop as given, second stop high
	task automatic bang_frame(input uart_byte_t data, input logic stop_level);
		exp_q.push_back({!stop_level, data});
		hold_line(1'b0);
		for (int i = 0; i < data_bits; i++)
			hold_line(data[i]);
		hold_line(stop_level);
		hold_line(1'b1);
	endtask

	task automatic idle_after_reset();
		test_name = "reset_state";
		if (tx !== 1'b1)
			value_mismatch("tx after reset", 1, int'(tx));
		if (tx_busy !== 1'b0)
			value_mismatch("tx_busy after reset", 0, int'(tx_busy));
		if (credit_ret !== 1'b0)
			value_mismatch("credit_ret after reset", 0, int'(credit_ret));
		repeat (idle_cycles) begin
			@(negedge sys_clk);
			if (rx_beat.valid !== 1'b0)
				value_mismatch("rx_beat.valid on idle line", 0, int'(rx_beat.valid));
		end
	endtask

	task automatic loopback_random();
		test_name = "loopback";
		use_gaps = 1'b1;
		repeat (loop_bytes)
			send_q.push_back(uart_byte_t'($random(seed)));
		wait_drained("loopback", drain_limit);
		credit_totals();
	endtask

	task automatic full_credit_burst();
		test_name = "full_burst";
		use_gaps = 1'b0;
		min_credits = credits;
		repeat (burst_bytes)
			send_q.push_back(uart_byte_t'($random(seed)));
		wait_drained("full_burst", drain_limit);
		if (min_credits != 0)
			value_mismatch("lowest credit count in burst", 0, min_credits);
		credit_totals();
	endtask

	task automatic framing_error_frames();
		test_name = "framing_error";
		@(posedge sys_clk);
		line_sel <= 1'b0;
		bang_frame(uart_byte_t'($random(seed)), 1'b0);
		bang_frame(uart_byte_t'($random(seed)), 1'b1);
		hold_line(1'b1);	// idle line
		wait_drained("framing_error", idle_limit);
	endtask

	initial begin : main_seq
		seed           = 32'h557b_ec3b;
		sys_rst_n      = 1'b0;
		host_beat      = '0;
		line_sel       = 1'b1;
		bang_line      = 1'b1;
		use_gaps       = 1'b0;
		credits        = fifo_depth;
		min_credits    = fifo_depth;
		gap_left       = 0;
		bytes_sent     = 0;
		credit_pulses  = 0;
		frames_checked = 0;
		error_cnt      = 0;
		timeout_cnt    = 0;
		test_name      = "init";
		repeat (2) @(posedge sys_clk);
		sys_rst_n <= 1'b1;
		@(negedge sys_clk);
		idle_after_reset();
		if (timeout_cnt == 0)
			loopback_random();
		if (timeout_cnt == 0)
			full_credit_burst();
		if (timeout_cnt == 0)
			framing_error_frames();
		$display("errors=%0d timeouts=%0d bytes_sent=%0d credits_returned=%0d frames=%0d",
			error_cnt, timeout_cnt, bytes_sent, credit_pulses, frames_checked);
		if (error_cnt == 0 && timeout_cnt == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

// File: build.f
src/uart_pkg.sv
src/tx_credit_fifo.sv
src/uart_tx.sv
src/uart_rx.sv
src/uart_top.sv
verification/uart_tb.sv

// File: Makefile
# Verilator build and run for the uart subsystem testbench

VERILATOR  ?= verilator
TOP        ?= uart_tb
RTL_TOP    ?= uart_top
FILELIST   ?= build.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
FAIL_MSG   ?= === FAIL ===
VFLAGS     ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the log is searched for the fail line; a crashed run also counts as failure
run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ]; then echo "simulation exited with status $$status"; exit 1; fi
	@if grep -qF -- "$(FAIL_MSG)" $(LOG); then echo "simulation reported failure"; exit 1; fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
